// ==== audioPcm_defs.svh ====
`ifndef AUDIO_PCM_DEFS_SVH
`define AUDIO_PCM_DEFS_SVH

// device code, compared against address bits 27..16
`define DEV_SELECT      12'h009

// sample area decoded from address bits 15..14
`define AREA_SAMPLES    2'h0
// control area decoded from address bits 15..12
`define AREA_CONTROL    4'hF

// register indices in address bits 7..2
`define REG_CTRL0       6'h00
`define REG_CTRL1       6'h01
`define REG_POSITION    6'h08

// index width of one memory bank, 1024 words each
`define BLOCK_BITS      10
// sample position, 8 bytes per 64-bit block
`define POS_BITS        13

// opcode bits
`define OP_READ_BIT     3
`define OP_WRITE_BIT    4

// extra registers on pwmOut and pwmEna
`define PWM_DELAY       4

`endif

// ==== audioPcmPkg.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

package audioPcmPkg;

	// bus words
	typedef logic [31:0] busAddr_t;
	typedef logic [31:0] busData_t;
	typedef logic [4:0] busOp_t;

	// response code, returned two cycles after a selected request
	typedef enum logic [1:0]
	{
		READY = 2'd0,
		OK = 2'd1
	} busStatus_t;

	// rate table code, ctrl0 bits 7..4
	typedef logic [3:0] rateSel_t;
	typedef logic [`POS_BITS-1:0] samplePos_t;

	// decoded sample, signed
	typedef logic signed [15:0] pcmSample_t;
	// pwm level, 0x8000 is silence
	typedef logic [15:0] pwmLevel_t;
	typedef logic signed [11:0] auxSample_t;

endpackage

`default_nettype wire

// ==== pcmBusRegs.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

module pcmBusRegs
(
	input wire logic clock,
	input wire logic reset,
	input wire audioPcmPkg::busAddr_t busAddr,
	input wire audioPcmPkg::busData_t busData,
	input wire audioPcmPkg::busOp_t busOp,
	input wire audioPcmPkg::samplePos_t samplePos,
	output audioPcmPkg::busData_t readData,
	output audioPcmPkg::busStatus_t busStatus,
	output logic memWrite,
	output logic memBank,
	output logic [`BLOCK_BITS-1:0] memIndex,
	output audioPcmPkg::busData_t memData,
	output logic useCompand,
	output logic use16b,
	output logic outEnable,
	output audioPcmPkg::rateSel_t rateSel,
	output logic [15:0] beepDivisor
);

	// request as seen one cycle after the bus
	audioPcmPkg::busAddr_t reqAddr;
	audioPcmPkg::busData_t reqData;
	audioPcmPkg::busOp_t reqOp;
	audioPcmPkg::busData_t ctrl0;
	audioPcmPkg::busData_t ctrl1;
	audioPcmPkg::busData_t readNext;
	logic devSel;
	logic ctrlSel;
	logic sampleSel;
	logic reqRead;
	logic reqWrite;

	// opcode is control state, address and data are payload
	always_ff @(posedge clock)
	begin
		if (reset)
			reqOp <= '0;
		else
			reqOp <= busOp;
	end

	always_ff @(posedge clock)
	begin
		reqAddr <= busAddr;
		reqData <= busData;
	end

	// device and area decode
	assign devSel = (reqAddr[27:16] == `DEV_SELECT);
	assign ctrlSel = devSel && (reqAddr[15:12] == `AREA_CONTROL);
	assign sampleSel = devSel && (reqAddr[15:14] == `AREA_SAMPLES);
	assign reqRead = reqOp[`OP_READ_BIT];
	assign reqWrite = reqOp[`OP_WRITE_BIT];

	// sample writes go out now, land in the buffer at the next edge
	// bit 2 picks the bank, the word index sits above it
	assign memWrite = sampleSel && reqWrite;
	assign memBank = reqAddr[2];
	assign memIndex = reqAddr[`BLOCK_BITS+2:3];
	assign memData = reqData;

	// readback mux, zero for anything not mapped
	always_comb
	begin
		readNext = '0;
		if (ctrlSel && reqRead)
		begin
			case (reqAddr[7:2])
				`REG_CTRL0: readNext = ctrl0;
				`REG_CTRL1: readNext = ctrl1;
				`REG_POSITION: readNext = {{(32-`POS_BITS){1'b0}}, samplePos};
				default: readNext = '0;
			endcase
		end
	end

	// response and register writes share one edge
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			readData <= '0;
			busStatus <= audioPcmPkg::READY;
			ctrl0 <= '0;
			ctrl1 <= '0;
		end
		else
		begin
			readData <= readNext;
			// any selected read or write completes, no wait states
			if (devSel && (reqRead || reqWrite))
				busStatus <= audioPcmPkg::OK;
			else
				busStatus <= audioPcmPkg::READY;
			if (ctrlSel && reqWrite)
			begin
				case (reqAddr[7:2])
					`REG_CTRL0: ctrl0 <= reqData;
					`REG_CTRL1: ctrl1 <= reqData;
					default: ;
				endcase
			end
		end
	end

	// control fields as levels
	assign useCompand = ctrl0[0];
	assign use16b = ctrl0[1];
	// bit 2 was stereo, kept only in readback
	assign outEnable = ctrl0[3];
	assign rateSel = ctrl0[7:4];
	assign beepDivisor = ctrl1[15:0];

endmodule

`default_nettype wire

// ==== sampleRateTimer.sv ====
`default_nettype none

module sampleRateTimer
(
	input wire logic clock,
	input wire logic reset,
	input wire audioPcmPkg::rateSel_t rateSel,
	output audioPcmPkg::samplePos_t samplePos
);

	logic [13:0] tableValue;
	logic [13:0] reloadValue;
	logic [13:0] divCount;

	// divider reloads for a 50 MHz clock
	// 8, 16, 22.05, 32, 44.1 kHz rows and a few spares
	always_comb
	begin
		case (rateSel)
			4'h0: tableValue = 14'd6250;
			4'h1: tableValue = 14'd4535;
			4'h2: tableValue = 14'd3125;
			4'h3: tableValue = 14'd2268;
			4'h4: tableValue = 14'd1562;
			4'h5: tableValue = 14'd1134;
			4'h6: tableValue = 14'd781;
			4'h7: tableValue = 14'd567;
			4'h9: tableValue = 14'd1042;
			4'hB: tableValue = 14'd521;
			// remaining codes all run at 128 kHz
			default: tableValue = 14'd390;
		endcase
	end

	always_ff @(posedge clock)
	begin
		reloadValue <= tableValue;
	end

	// one position step every reloadValue+1 cycles
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			divCount <= '0;
			samplePos <= '0;
		end
		else if (divCount == 14'd0)
		begin
			divCount <= reloadValue;
			samplePos <= samplePos + 1'b1;
		end
		else
			divCount <= divCount - 1'b1;
	end

endmodule

`default_nettype wire

// ==== pcmSampleBuffer.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

module pcmSampleBuffer
(
	input wire logic clock,
	input wire logic memWrite,
	input wire logic memBank,
	input wire logic [`BLOCK_BITS-1:0] memIndex,
	input wire audioPcmPkg::busData_t memData,
	input wire audioPcmPkg::samplePos_t samplePos,
	input wire logic use16b,
	output logic [7:0] sampleByte,
	output logic [15:0] sampleWord
);

	// bank A holds the low word of each block, bank B the high word
	logic [31:0] bankA [0:(1<<`BLOCK_BITS)-1];
	logic [31:0] bankB [0:(1<<`BLOCK_BITS)-1];
	logic [`BLOCK_BITS-1:0] blockIndex;
	logic [63:0] block;
	// position low bits travel with the block they select from
	logic [2:0] blockSel;

	// bus write port
	always_ff @(posedge clock)
	begin
		if (memWrite)
		begin
			if (memBank)
				bankB[memIndex] <= memData;
			else
				bankA[memIndex] <= memData;
		end
	end

	// 8 bytes or 4 halfwords per block
	assign blockIndex = use16b ? samplePos[`BLOCK_BITS+1:2] : samplePos[`BLOCK_BITS+2:3];

	always_ff @(posedge clock)
	begin
		block <= {bankB[blockIndex], bankA[blockIndex]};
		blockSel <= samplePos[2:0];
	end

	// field select, both widths registered, decoder picks one
	always_ff @(posedge clock)
	begin
		sampleByte <= block[8*blockSel +: 8];
		sampleWord <= block[16*blockSel[1:0] +: 16];
	end

endmodule

`default_nettype wire

// ==== pcmDecoder.sv ====
`default_nettype none

module pcmDecoder
(
	input wire logic clock,
	input wire logic [7:0] sampleByte,
	input wire logic [15:0] sampleWord,
	input wire logic useCompand,
	input wire logic use16b,
	output audioPcmPkg::pcmSample_t pcmValue
);

	// S.E3.M4 fields
	logic [2:0] expField;
	logic [3:0] mantField;
	logic [10:0] magnitude;
	// 12-bit candidates, one per format
	logic [11:0] compandVal;
	logic [11:0] linearVal;
	logic [11:0] wordVal;
	logic [11:0] chosenVal;

	assign expField = sampleByte[6:4];
	assign mantField = sampleByte[3:0];

	// E=0 is denormal, otherwise hidden one shifted by E-1
	assign magnitude = (expField == 3'd0) ? {7'b0, mantField} :
		({6'b0, 1'b1, mantField} << (expField - 3'd1));

	always_ff @(posedge clock)
	begin
		// negative codes are ones-complemented under the sign
		if (sampleByte[7])
			compandVal <= {1'b1, ~magnitude};
		else
			compandVal <= {1'b0, magnitude};
		// unsigned byte, flip the top bit to get two's complement
		linearVal <= {~sampleByte[7], sampleByte[6:0], 4'h0};
		// 16-bit data is unsigned unless compand is set
		wordVal <= {sampleWord[15] ^ ~useCompand, sampleWord[14:4]};
	end

	assign chosenVal = use16b ? wordVal : (useCompand ? compandVal : linearVal);

	// widen to 16 bits by repeating the top nibble
	always_ff @(posedge clock)
	begin
		pcmValue <= {chosenVal, chosenVal[11:8]};
	end

endmodule

`default_nettype wire

// ==== pcmMixer.sv ====
`default_nettype none

module pcmMixer
(
	input wire logic clock,
	input wire logic reset,
	input wire audioPcmPkg::pcmSample_t pcmValue,
	input wire audioPcmPkg::auxSample_t auxPcm,
	input wire logic timer1MHz,
	input wire logic [15:0] beepDivisor,
	output audioPcmPkg::pwmLevel_t pwmLevel
);

	audioPcmPkg::auxSample_t auxReg;
	logic signed [15:0] auxWide;
	logic signed [15:0] mixSum;
	logic signed [15:0] sumReg;
	// divisor pipeline, beeper starts two cycles after a write
	logic [15:0] beepDelay1;
	logic [15:0] beepDelay2;
	logic beepEna;
	logic [15:0] beepCount;
	logic beepPhase;
	logic tick;

	always_ff @(posedge clock)
	begin
		auxReg <= auxPcm;
		beepDelay1 <= beepDivisor;
		beepDelay2 <= beepDelay1;
	end

	assign beepEna = (beepDelay2 != 16'd0);

	// tone generator, phase flips on each count underflow
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tick <= 1'b0;
			beepCount <= '0;
			beepPhase <= 1'b0;
		end
		else
		begin
			tick <= timer1MHz;
			if (beepCount == 16'd0)
			begin
				beepCount <= beepDelay2;
				beepPhase <= ~beepPhase;
			end
			else
				beepCount <= beepCount - {15'b0, tick};
		end
	end

	// aux halved, then scaled by 8
	assign auxWide = auxReg >>> 1;

	always_comb
	begin
		if (beepEna)
			mixSum = beepPhase ? 16'sh0FFF : -16'sh1000;
		else
			mixSum = (pcmValue >>> 2) + (auxWide <<< 3);
	end

	always_ff @(posedge clock)
	begin
		sumReg <= mixSum;
	end

	// clip to +-0x2000, then offset and scale into the 16-bit level
	always_ff @(posedge clock)
	begin
		if (sumReg > 16'sh1FFF)
			pwmLevel <= 16'hFFFF;
		else if (sumReg < -16'sh2000)
			pwmLevel <= 16'h0000;
		else
			pwmLevel <= 16'h8000 + {sumReg[13:0], 2'b00};
	end

endmodule

`default_nettype wire

// ==== deltaSigmaPwm.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

module deltaSigmaPwm
(
	input wire logic clock,
	input wire logic reset,
	input wire audioPcmPkg::pwmLevel_t pwmLevel,
	input wire logic outEnable,
	output logic pwmOut,
	output logic pwmEna
);

	logic [15:0] accum;
	logic [16:0] accumSum;
	logic rawOut;
	logic [`PWM_DELAY-1:0] outLine;
	logic [`PWM_DELAY-1:0] enaLine;

	// first order modulator, carry out is the bit stream
	assign accumSum = {1'b0, accum} + {1'b0, pwmLevel};
	// idle line sits high
	assign rawOut = outEnable ? accumSum[16] : 1'b1;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			accum <= '0;
			outLine <= '1;
			enaLine <= '0;
		end
		else
		begin
			// accumulator parked at zero while output is off
			accum <= outEnable ? accumSum[15:0] : 16'h0000;
			outLine <= {outLine[`PWM_DELAY-2:0], rawOut};
			enaLine <= {enaLine[`PWM_DELAY-2:0], outEnable};
		end
	end

	assign pwmOut = outLine[`PWM_DELAY-1];
	assign pwmEna = enaLine[`PWM_DELAY-1];

endmodule

`default_nettype wire

// ==== audioPcmDevice.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

module audioPcmDevice
(
	input wire logic clock,
	input wire logic reset,
	input wire audioPcmPkg::busAddr_t busAddr,
	input wire audioPcmPkg::busData_t busData,
	input wire audioPcmPkg::busOp_t busOp,
	input wire audioPcmPkg::auxSample_t auxPcm,
	input wire logic timer1MHz,
	output audioPcmPkg::busData_t readData,
	output audioPcmPkg::busStatus_t busStatus,
	output logic pwmOut,
	output logic pwmEna
);

	// bus to sample memory
	logic memWrite;
	logic memBank;
	logic [`BLOCK_BITS-1:0] memIndex;
	audioPcmPkg::busData_t memData;
	// control fields
	logic useCompand;
	logic use16b;
	logic outEnable;
	audioPcmPkg::rateSel_t rateSel;
	logic [15:0] beepDivisor;
	// sample path
	audioPcmPkg::samplePos_t samplePos;
	logic [7:0] sampleByte;
	logic [15:0] sampleWord;
	audioPcmPkg::pcmSample_t pcmValue;
	audioPcmPkg::pwmLevel_t pwmLevel;

	pcmBusRegs busRegs
	(
		.clock(clock), .reset(reset),
		.busAddr(busAddr), .busData(busData), .busOp(busOp), .samplePos(samplePos),
		.readData(readData), .busStatus(busStatus),
		.memWrite(memWrite), .memBank(memBank), .memIndex(memIndex), .memData(memData),
		.useCompand(useCompand), .use16b(use16b), .outEnable(outEnable),
		.rateSel(rateSel), .beepDivisor(beepDivisor)
	);

	sampleRateTimer rateTimer
	(
		.clock(clock), .reset(reset), .rateSel(rateSel), .samplePos(samplePos)
	);

	pcmSampleBuffer sampleBuffer
	(
		.clock(clock),
		.memWrite(memWrite), .memBank(memBank), .memIndex(memIndex), .memData(memData),
		.samplePos(samplePos), .use16b(use16b),
		.sampleByte(sampleByte), .sampleWord(sampleWord)
	);

	pcmDecoder decoder
	(
		.clock(clock), .sampleByte(sampleByte), .sampleWord(sampleWord),
		.useCompand(useCompand), .use16b(use16b), .pcmValue(pcmValue)
	);

	pcmMixer mixer
	(
		.clock(clock), .reset(reset), .pcmValue(pcmValue), .auxPcm(auxPcm),
		.timer1MHz(timer1MHz), .beepDivisor(beepDivisor), .pwmLevel(pwmLevel)
	);

	deltaSigmaPwm modulator
	(
		.clock(clock), .reset(reset), .pwmLevel(pwmLevel), .outEnable(outEnable),
		.pwmOut(pwmOut), .pwmEna(pwmEna)
	);

endmodule

`default_nettype wire

// ==== audioPcmDevice_assertions.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

module audioPcmDevice_assertions
(
	input wire logic clock,
	input wire logic reset,
	input wire audioPcmPkg::busAddr_t busAddr,
	input wire audioPcmPkg::busOp_t busOp,
	input wire audioPcmPkg::busStatus_t busStatus,
	input wire logic pwmOut,
	input wire logic pwmEna
);

	timeunit 1ns;
	timeprecision 1ps;

	logic selected;

	// read or write aimed at this device
	assign selected = (busAddr[27:16] == `DEV_SELECT) &&
		(busOp[`OP_READ_BIT] || busOp[`OP_WRITE_BIT]);

	// line idles high while the output stage is off
	idleHigh: assert property (@(posedge clock) disable iff (reset) !pwmEna |-> pwmOut)
		else $error("pwmOut low while pwmEna is low");

	okAfterRequest: assert property (@(posedge clock) disable iff (reset)
		(busStatus == audioPcmPkg::OK) |-> $past(selected, 2))
		else $error("busStatus OK without a selected request two cycles before");

	outKnown: assert property (@(posedge clock) disable iff (reset) !$isunknown(pwmOut))
		else $error("pwmOut unknown after reset");

endmodule

`default_nettype wire

// ==== audioPcmDevice_tb.sv ====
`default_nettype none

`include "audioPcm_defs.svh"

module audioPcmDevice_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_LINES = 64;
	// kind, ctrl0, ctrl1, fill, aux, window, expected
	localparam int COLUMNS = 7;
	// one write per 32-bit word, both banks
	localparam int FILL_WORDS = 2 << `BLOCK_BITS;
	// whole sample path is well under this
	localparam int SETTLE_CYCLES = 64;
	localparam audioPcmPkg::busOp_t OP_IDLE = 5'b00000;
	localparam audioPcmPkg::busOp_t OP_READ = 5'b00001 << `OP_READ_BIT;
	localparam audioPcmPkg::busOp_t OP_WRITE = 5'b00001 << `OP_WRITE_BIT;
	localparam audioPcmPkg::busAddr_t SAMPLE_BASE = {4'h0, `DEV_SELECT, 16'h0000};
	localparam audioPcmPkg::busAddr_t CTRL_BASE = {4'h0, `DEV_SELECT, `AREA_CONTROL, 12'h000};

	logic clock;
	logic reset;
	audioPcmPkg::busAddr_t busAddr;
	audioPcmPkg::busData_t busData;
	audioPcmPkg::busOp_t busOp;
	audioPcmPkg::auxSample_t auxPcm;
	logic timer1MHz;
	audioPcmPkg::busData_t readData;
	audioPcmPkg::busStatus_t busStatus;
	logic pwmOut;
	logic pwmEna;

	logic [31:0] testWords [0:MAX_LINES*COLUMNS-1];
	int lineCount;
	int watchLimit;
	int seed;

	audioPcmDevice uut
	(
		.clock(clock), .reset(reset),
		.busAddr(busAddr), .busData(busData), .busOp(busOp),
		.auxPcm(auxPcm), .timer1MHz(timer1MHz),
		.readData(readData), .busStatus(busStatus),
		.pwmOut(pwmOut), .pwmEna(pwmEna)
	);

	bind audioPcmDevice audioPcmDevice_assertions assertChecks
	(
		.clock(clock), .reset(reset), .busAddr(busAddr), .busOp(busOp),
		.busStatus(busStatus), .pwmOut(pwmOut), .pwmEna(pwmEna)
	);

	// 20 ns clock
	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abortRun();
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	// budget is known once the vector file is read
	initial
	begin
		wait (watchLimit != 0);
		repeat (watchLimit) @(posedge clock);
		$display("timeout, tests still running after %0d cycles", watchLimit);
		abortRun();
	end

	task automatic checkData(input string name, input audioPcmPkg::busData_t actual,
		input audioPcmPkg::busData_t expected);
		if (actual !== expected)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
			abortRun();
		end
	endtask

	task automatic checkStatus(input string name, input audioPcmPkg::busStatus_t actual,
		input audioPcmPkg::busStatus_t expected);
		if (actual !== expected)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
			abortRun();
		end
	endtask

	task automatic checkPin(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
			abortRun();
		end
	endtask

	// position steps may land one either way of the window edge
	task automatic checkPosition(input string name, input audioPcmPkg::samplePos_t step,
		input audioPcmPkg::samplePos_t expected);
		if (step > expected + 1'b1 || step + 1'b1 < expected)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h +-1", name, step, expected);
			abortRun();
		end
	endtask

	// ones over the window against level*window/65536
	task automatic checkLevelCount(input string name, input int count,
		input audioPcmPkg::pwmLevel_t level, input int window, input int tol);
		longint exact;
		longint scaled;
		exact = longint'(level) * window;
		scaled = longint'(count) * 65536;
		if (scaled > exact + tol * 65536 || scaled < exact - tol * 65536)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h +-%0d (level 0x%h)",
				name, count, exact >> 16, tol, level);
			abortRun();
		end
	endtask

	function automatic audioPcmPkg::busAddr_t regAddr(input logic [5:0] index);
		return CTRL_BASE | {24'h0, index, 2'b00};
	endfunction

	// one request, then the fixed two-cycle response
	task automatic busAccess(input audioPcmPkg::busOp_t op, input audioPcmPkg::busAddr_t addr,
		input audioPcmPkg::busData_t data, output audioPcmPkg::busData_t result);
		@(posedge clock);
		busAddr <= addr;
		busData <= data;
		busOp <= op;
		@(posedge clock);
		busOp <= OP_IDLE;
		@(posedge clock);
		@(negedge clock);
		checkStatus("busStatus", busStatus, audioPcmPkg::OK);
		result = readData;
		@(negedge clock);
		checkStatus("busStatus", busStatus, audioPcmPkg::READY);
	endtask

	task automatic writeReg(input logic [5:0] index, input audioPcmPkg::busData_t data);
		audioPcmPkg::busData_t unused;
		busAccess(OP_WRITE, regAddr(index), data, unused);
	endtask

	task automatic readReg(input logic [5:0] index, output audioPcmPkg::busData_t data);
		busAccess(OP_READ, regAddr(index), '0, data);
	endtask

	// wrong device code, random don't-care bits
	task automatic strayAccess();
		logic [31:0] rnd;
		rnd = $random(seed);
		@(posedge clock);
		busAddr <= {rnd[31:28], 12'h5A0, rnd[15:0]};
		busOp <= OP_READ;
		@(posedge clock);
		busOp <= OP_IDLE;
		@(posedge clock);
		@(negedge clock);
		checkStatus("busStatus", busStatus, audioPcmPkg::READY);
		@(negedge clock);
		checkStatus("busStatus", busStatus, audioPcmPkg::READY);
	endtask

	// back to back writes, bank in address bit 2
	task automatic fillMemory(input audioPcmPkg::busData_t word);
		for (int i = 0; i < FILL_WORDS; i++)
		begin
			@(posedge clock);
			busAddr <= SAMPLE_BASE | (i << 2);
			busData <= word;
			busOp <= OP_WRITE;
		end
		@(posedge clock);
		busOp <= OP_IDLE;
	endtask

	task automatic runRegisterTest(input audioPcmPkg::busData_t ctrl0,
		input audioPcmPkg::busData_t ctrl1, input audioPcmPkg::busData_t expected);
		audioPcmPkg::busData_t value;
		writeReg(`REG_CTRL0, ctrl0);
		writeReg(`REG_CTRL1, ctrl1);
		strayAccess();
		readReg(`REG_CTRL0, value);
		checkData("ctrl0", value, ctrl0);
		readReg(`REG_CTRL1, value);
		checkData("ctrl1", value, expected);
	endtask

	task automatic runPositionTest(input audioPcmPkg::busData_t ctrl0, input int window,
		input audioPcmPkg::samplePos_t expected);
		audioPcmPkg::busData_t first;
		audioPcmPkg::busData_t start;
		audioPcmPkg::busData_t finish;
		audioPcmPkg::samplePos_t step;
		writeReg(`REG_CTRL0, ctrl0);
		readReg(`REG_POSITION, first);
		start = first;
		// a step means the new reload value is in use
		while (start == first)
			readReg(`REG_POSITION, start);
		repeat (window) @(posedge clock);
		readReg(`REG_POSITION, finish);
		step = finish[`POS_BITS-1:0] - start[`POS_BITS-1:0];
		checkPosition("samplePos step", step, expected);
	endtask

	task automatic runLevelTest(input audioPcmPkg::busData_t ctrl0,
		input audioPcmPkg::busData_t ctrl1, input audioPcmPkg::busData_t fill,
		input audioPcmPkg::auxSample_t aux, input int window,
		input audioPcmPkg::pwmLevel_t level, input logic tone);
		int count;
		@(posedge clock);
		auxPcm <= aux;
		// tick every cycle while the beeper runs
		timer1MHz <= tone;
		fillMemory(fill);
		writeReg(`REG_CTRL1, ctrl1);
		writeReg(`REG_CTRL0, ctrl0);
		while (pwmEna !== 1'b1)
			@(negedge clock);
		repeat (SETTLE_CYCLES) @(negedge clock);
		count = 0;
		repeat (window)
		begin
			@(negedge clock);
			if (pwmOut)
				count++;
		end
		checkLevelCount("pwmOut ones", count, level, window, tone ? 2 : 1);
	endtask

	initial
	begin
		int base;
		int budget;
		audioPcmPkg::busData_t value;
		reset <= 1'b1;
		busAddr <= '0;
		busData <= '0;
		busOp <= OP_IDLE;
		auxPcm <= '0;
		timer1MHz <= 1'b0;
		watchLimit = 0;
		seed = 92;
		// all ones marks the end of the vectors
		for (int i = 0; i < MAX_LINES * COLUMNS; i++)
			testWords[i] = '1;
		$readmemh("audioPcmDevice_tests.txt", testWords);
		lineCount = 0;
		budget = 0;
		while (lineCount < MAX_LINES && testWords[lineCount * COLUMNS] != '1)
		begin
			budget += FILL_WORDS + int'(testWords[lineCount * COLUMNS + 5]) + 2000;
			lineCount++;
		end
		if (lineCount == 0)
		begin
			$display("no test vectors found in audioPcmDevice_tests.txt");
			abortRun();
		end
		watchLimit = budget;

		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		// output off and registers clear after reset
		checkPin("pwmEna", pwmEna, 1'b0);
		checkPin("pwmOut", pwmOut, 1'b1);
		checkStatus("busStatus", busStatus, audioPcmPkg::READY);
		readReg(`REG_CTRL0, value);
		checkData("ctrl0", value, '0);
		readReg(`REG_CTRL1, value);
		checkData("ctrl1", value, '0);

		for (int line = 0; line < lineCount; line++)
		begin
			base = line * COLUMNS;
			case (testWords[base])
				32'd0: runRegisterTest(testWords[base + 1], testWords[base + 2],
					testWords[base + 6]);
				32'd1: runPositionTest(testWords[base + 1], int'(testWords[base + 5]),
					testWords[base + 6][`POS_BITS-1:0]);
				32'd2, 32'd3: runLevelTest(testWords[base + 1], testWords[base + 2],
					testWords[base + 3], testWords[base + 4][11:0],
					int'(testWords[base + 5]), testWords[base + 6][15:0],
					testWords[base] == 32'd3);
				default:
				begin
					$display("unknown test kind %0d on vector line %0d", testWords[base], line);
					abortRun();
				end
			endcase
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== audioPcmDevice_tests.txt ====
// kind ctrl0 ctrl1 fill aux window expected, all hex
// kind 0 register readback, 1 position step, 2 pwm level, 3 beeper level
0 5A5A00A5 C3C30000 00000000 000 0 C3C30000
1 000000F0 00000000 00000000 000 F46 A
2 000000F8 00000000 C0C0C0C0 000 FA0 C004
2 000000F8 00000000 20202020 000 FA0 2008
2 000000FB 00000000 30003000 000 FA0 B000
2 000000FA 00000000 60006000 000 FA0 600C
2 000000F9 00000000 35353535 000 FA0 8540
2 000000F9 00000000 C8C8C8C8 000 FA0 73FC
2 000000F9 00000000 7F7F7F7F 000 FA0 FC04
2 000000F9 00000000 83838383 000 FA0 7FCC
2 000000FB 00000000 70007000 7FF FA0 FFFF
2 000000F8 00000000 00000000 800 FA0 0
2 000000F8 00000000 C0C0C0C0 E00 FA0 A004
3 000000F8 00000063 80808080 000 FA0 7FFE

// ==== audioPcmDevice.f ====
+incdir+.
audioPcmPkg.sv
pcmBusRegs.sv
sampleRateTimer.sv
pcmSampleBuffer.sv
pcmDecoder.sv
pcmMixer.sv
deltaSigmaPwm.sv
audioPcmDevice.sv
audioPcmDevice_assertions.sv
audioPcmDevice_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f audioPcmDevice.f --top-module audioPcmDevice_tb -o audioPcmDeviceSim
./obj_dir/audioPcmDeviceSim
